/* bz_pkg.sv */
package bz_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int word_w         = 32; // host pipe word
	localparam int flit_w         = 11; // board-to-board link flit
	localparam int flits_per_word = 3;
	localparam int payload_w      = 21; // BD-ward payload
	localparam int dest_w         = 4;
	localparam int drop_count_w   = 16;

	// ----------------------------------------
	// packet word layout
	// ----------------------------------------
	localparam int pkt_flag_bit = 31; // 0 marks a packet
	localparam int dest_lo      = 27;
	localparam int dest_hi      = dest_lo + dest_w - 1; // bit 30
	localparam int payload_lo   = 0;
	localparam int payload_hi   = payload_lo + payload_w - 1; // bit 20
	// bits 26..21 stay zero

	// ----------------------------------------
	// register write layout
	// ----------------------------------------
	localparam int         reg_tag_lo  = 29; // tag sits in 31..29
	localparam logic [2:0] reg_tag     = 3'b100; // 10 then a 0
	localparam int         reg_id_w    = 5;
	localparam int         reg_id_lo   = 24; // id in 28..24
	localparam int         reg_data_w  = 16;
	localparam int         reg_data_lo = 0; // data in 15..0

	// nop is 10000 in the top five bits, zeros below
	// note it decodes like a write of zero to reg 0
	localparam logic [word_w-1:0] nop_word = {5'b10000, 27'd0};

	// what the decoder makes of a host word
	typedef enum logic [1:0] {
		wk_packet,
		wk_reg_write,
		wk_nop,
		wk_reserved
	} word_kind_t;

	// reg 31 bit 0 holds the link
	localparam logic [reg_id_w-1:0] hold_reg_id = 5'd31;

endpackage

/* host_pipe_fifo.sv */
`timescale 1ns/1ps
module host_pipe_fifo #(
	parameter int depth = 8
) (
	input  logic                      osc,
	input  logic                      reset,
	input  logic [bz_pkg::word_w-1:0] pipe_in_data,
	input  logic                      pipe_in_valid,
	input  logic                      fifo_pop,
	output logic                      pipe_in_ready,
	output logic [bz_pkg::word_w-1:0] fifo_data,
	output logic                      fifo_valid
);
	import bz_pkg::*;

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	logic [word_w-1:0] mem [depth]; // circular store
	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [cnt_w-1:0]  count; // mem plus output reg
	logic              push;
	logic              mem_has; // something behind the output reg
	logic              load; // mem head moves to output

	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1; // wrap at depth
	endfunction

	assign pipe_in_ready = (count != cnt_w'(depth)); // low only when full
	assign push          = pipe_in_valid && pipe_in_ready;
	assign mem_has       = (count > cnt_w'(fifo_valid));
	assign load          = mem_has && (!fifo_valid || fifo_pop);

	// ----------------------------------------
	// pointers, occupancy, output flag
	// ----------------------------------------
	always_ff @(posedge osc) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			fifo_valid <= 1'b0;
		end else begin
			count <= count + cnt_w'(push) - cnt_w'(fifo_pop); // push and pop together
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (load) begin
				rd_ptr     <= ptr_inc(rd_ptr);
				fifo_valid <= 1'b1;
			end else if (fifo_pop) begin
				fifo_valid <= 1'b0; // drained
			end
		end
	end

	// storage and output word, one edge behind the write
	always_ff @(posedge osc) begin
		if (push)
			mem[wr_ptr] <= pipe_in_data;
		if (load)
			fifo_data <= mem[rd_ptr];
	end

endmodule

/* host_word_decoder.sv */
`timescale 1ns/1ps
module host_word_decoder (
	input  logic                      osc,
	input  logic                      reset,
	input  logic [bz_pkg::word_w-1:0] fifo_data,
	input  logic                      fifo_valid,
	input  logic                      word_ready,
	output logic                      fifo_pop,
	output logic [bz_pkg::word_w-1:0] word_data,
	output logic                      word_valid,
	output logic                      link_hold
);
	import bz_pkg::*;

	word_kind_t            kind;
	logic [reg_id_w-1:0]   reg_id;
	logic [reg_data_w-1:0] reg_data;
	logic                  hold_write;

	// ----------------------------------------
	// word classification
	// ----------------------------------------
	// nop checked first, it shares the write tag
	function automatic word_kind_t classify(input logic [word_w-1:0] w);
		word_kind_t k;
		if (w == nop_word)
			k = wk_nop;
		else if (!w[pkt_flag_bit])
			k = wk_packet; // top bit clear
		else if (w[word_w-1:reg_tag_lo] == reg_tag)
			k = wk_reg_write;
		else
			k = wk_reserved; // 11x, 101 and friends
		return k;
	endfunction

	assign kind     = classify(fifo_data);
	assign reg_id   = fifo_data[reg_id_lo +: reg_id_w];
	assign reg_data = fifo_data[reg_data_lo +: reg_data_w];

	// packets ride the serializer handshake
	assign word_data  = fifo_data;
	assign word_valid = fifo_valid && (kind == wk_packet);

	// anything else leaves the fifo at once
	always_comb begin
		fifo_pop = 1'b0;
		if (fifo_valid) begin
			unique case (kind)
				wk_packet:    fifo_pop = word_ready;
				wk_reg_write: fifo_pop = 1'b1;
				wk_nop:       fifo_pop = 1'b1; // discarded
				wk_reserved:  fifo_pop = 1'b1; // discarded
			endcase
		end
	end

	// ----------------------------------------
	// host config, only the hold bit is kept
	// ----------------------------------------
	assign hold_write = fifo_valid && (kind == wk_reg_write) && (reg_id == hold_reg_id);

	always_ff @(posedge osc) begin
		if (reset)
			link_hold <= 1'b0;
		else if (hold_write)
			link_hold <= reg_data[0]; // same edge as the pop
	end

endmodule

/* link_serializer.sv */
`timescale 1ns/1ps
module link_serializer (
	input  logic                      osc,
	input  logic                      reset,
	input  logic [bz_pkg::word_w-1:0] word_data,
	input  logic                      word_valid,
	input  logic                      link_hold,
	input  logic                      link_ready,
	output logic                      word_ready,
	output logic [bz_pkg::flit_w-1:0] link_data,
	output logic                      link_valid
);
	import bz_pkg::*;

	localparam int               idx_w    = $clog2(flits_per_word);
	localparam logic [idx_w-1:0] last_idx = idx_w'(flits_per_word - 1);

	typedef enum logic {
		ser_idle,
		ser_send
	} ser_state_t;

	ser_state_t        state;
	logic [word_w-1:0] shift_reg; // low flit goes out first
	logic [idx_w-1:0]  flit_idx;
	logic              load;
	logic              flit_sent;

	// hold only blocks new words
	assign word_ready = (state == ser_idle) && !link_hold;
	assign load       = word_valid && word_ready;

	assign link_valid = (state == ser_send);
	assign link_data  = shift_reg[flit_w-1:0];
	assign flit_sent  = link_valid && link_ready;

	// ----------------------------------------
	// FSM and flit count
	// ----------------------------------------
	always_ff @(posedge osc) begin
		if (reset) begin
			state    <= ser_idle;
			flit_idx <= '0;
		end else begin
			case (state)
				ser_idle: begin
					if (load) begin
						state    <= ser_send;
						flit_idx <= '0;
					end
				end
				ser_send: begin
					if (flit_sent) begin
						if (flit_idx == last_idx) begin
							state    <= ser_idle; // word done
							flit_idx <= '0;
						end else begin
							flit_idx <= flit_idx + 1'b1;
						end
					end
				end
				default: state <= ser_idle;
			endcase
		end
	end

	// zeros shift in, so flit 2 gets a clear top bit
	always_ff @(posedge osc) begin
		if (load)
			shift_reg <= word_data;
		else if (flit_sent)
			shift_reg <= shift_reg >> flit_w;
	end

endmodule

/* host_core.sv */
`timescale 1ns/1ps
module host_core #(
	parameter int fifo_depth = 8
) (
	input  logic                      osc,
	input  logic                      reset,
	// host pipe
	input  logic [bz_pkg::word_w-1:0] pipe_in_data,
	input  logic                      pipe_in_valid,
	output logic                      pipe_in_ready,
	// link toward the stack
	output logic [bz_pkg::flit_w-1:0] link_data,
	output logic                      link_valid,
	input  logic                      link_ready
);
	import bz_pkg::*;

	logic [word_w-1:0] fifo_data;
	logic              fifo_valid;
	logic              fifo_pop;
	logic [word_w-1:0] word_data; // packet words only
	logic              word_valid;
	logic              word_ready;
	logic              link_hold; // from reg 31

	host_pipe_fifo #(.depth(fifo_depth)) u_fifo (
		.osc           (osc),
		.reset         (reset),
		.pipe_in_data  (pipe_in_data),
		.pipe_in_valid (pipe_in_valid),
		.fifo_pop      (fifo_pop),
		.pipe_in_ready (pipe_in_ready),
		.fifo_data     (fifo_data),
		.fifo_valid    (fifo_valid)
	);

	host_word_decoder u_decoder (
		.osc        (osc),
		.reset      (reset),
		.fifo_data  (fifo_data),
		.fifo_valid (fifo_valid),
		.word_ready (word_ready),
		.fifo_pop   (fifo_pop),
		.word_data  (word_data),
		.word_valid (word_valid),
		.link_hold  (link_hold)
	);

	link_serializer u_serializer (
		.osc        (osc),
		.reset      (reset),
		.word_data  (word_data),
		.word_valid (word_valid),
		.link_hold  (link_hold),
		.link_ready (link_ready),
		.word_ready (word_ready),
		.link_data  (link_data),
		.link_valid (link_valid)
	);

endmodule

/* link_deserializer.sv */
`timescale 1ns/1ps
module link_deserializer (
	input  logic                      osc,
	input  logic                      reset,
	input  logic [bz_pkg::flit_w-1:0] link_data,
	input  logic                      link_valid,
	input  logic                      word_take,
	output logic                      link_ready,
	output logic [bz_pkg::word_w-1:0] rx_word,
	output logic                      rx_valid
);
	import bz_pkg::*;

	localparam int               idx_w    = $clog2(flits_per_word);
	localparam logic [idx_w-1:0] last_idx = idx_w'(flits_per_word - 1);
	localparam int               last_w   = word_w - (flits_per_word - 1) * flit_w; // 10 bits

	logic [idx_w-1:0] flit_idx; // word boundary by count only
	logic             flit_in;

	assign link_ready = !rx_valid; // stall while a word waits
	assign flit_in    = link_valid && link_ready;

	// ----------------------------------------
	// flit count and word flag
	// ----------------------------------------
	always_ff @(posedge osc) begin
		if (reset) begin
			flit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			if (flit_in) begin
				if (flit_idx == last_idx) begin
					flit_idx <= '0;
					rx_valid <= 1'b1; // whole word next cycle
				end else begin
					flit_idx <= flit_idx + 1'b1;
				end
			end else if (word_take) begin
				rx_valid <= 1'b0;
			end
		end
	end

	// assembly, low flit first
	always_ff @(posedge osc) begin
		if (flit_in) begin
			if (flit_idx == last_idx)
				rx_word[word_w-1 -: last_w] <= link_data[last_w-1:0]; // top bit is pad
			else
				rx_word[int'(flit_idx) * flit_w +: flit_w] <= link_data;
		end
	end

endmodule

/* stack_core.sv */
`timescale 1ns/1ps
module stack_core #(
	parameter logic [bz_pkg::dest_w-1:0] stack_id = '0
) (
	input  logic                            osc,
	input  logic                            reset,
	// link from the host
	input  logic [bz_pkg::flit_w-1:0]       link_data,
	input  logic                            link_valid,
	output logic                            link_ready,
	// BD-ward output
	output logic [bz_pkg::payload_w-1:0]    bd_out_data,
	output logic                            bd_out_valid,
	input  logic                            bd_out_ready,
	output logic [bz_pkg::drop_count_w-1:0] drop_count
);
	import bz_pkg::*;

	logic [word_w-1:0] rx_word;
	logic              rx_valid;
	logic              word_take;
	logic              dest_match;
	logic              out_free; // empty or draining

	link_deserializer u_deser (
		.osc        (osc),
		.reset      (reset),
		.link_data  (link_data),
		.link_valid (link_valid),
		.word_take  (word_take),
		.link_ready (link_ready),
		.rx_word    (rx_word),
		.rx_valid   (rx_valid)
	);

	assign dest_match = (rx_word[dest_hi:dest_lo] == stack_id);
	assign out_free   = !bd_out_valid || bd_out_ready;
	assign word_take  = rx_valid && (!dest_match || out_free); // misses go at once

	// ----------------------------------------
	// output flag and drop counter
	// ----------------------------------------
	always_ff @(posedge osc) begin
		if (reset) begin
			bd_out_valid <= 1'b0;
			drop_count   <= '0;
		end else begin
			if (word_take && dest_match)
				bd_out_valid <= 1'b1;
			else if (bd_out_ready)
				bd_out_valid <= 1'b0;
			if (word_take && !dest_match)
				drop_count <= drop_count + 1'b1; // not ours
		end
	end

	always_ff @(posedge osc) begin
		if (word_take && dest_match)
			bd_out_data <= rx_word[payload_hi:payload_lo];
	end

endmodule

/* bz_link_top.sv */
`timescale 1ns/1ps
module bz_link_top #(
	parameter int                        fifo_depth = 8,
	parameter logic [bz_pkg::dest_w-1:0] stack_id   = 4'd5
) (
	input  logic                            osc, // one clock for host, link and stack
	input  logic                            reset,
	// host pipe
	input  logic [bz_pkg::word_w-1:0]       pipe_in_data,
	input  logic                            pipe_in_valid,
	output logic                            pipe_in_ready,
	// BD-ward
	output logic [bz_pkg::payload_w-1:0]    bd_out_data,
	output logic                            bd_out_valid,
	input  logic                            bd_out_ready,
	output logic [bz_pkg::drop_count_w-1:0] drop_count
);
	import bz_pkg::*;

	// board-to-board link, no clock of its own
	logic [flit_w-1:0] link_data;
	logic              link_valid;
	logic              link_ready;

	host_core #(.fifo_depth(fifo_depth)) u_host (
		.osc           (osc),
		.reset         (reset),
		.pipe_in_data  (pipe_in_data),
		.pipe_in_valid (pipe_in_valid),
		.pipe_in_ready (pipe_in_ready),
		.link_data     (link_data),
		.link_valid    (link_valid),
		.link_ready    (link_ready)
	);

	stack_core #(.stack_id(stack_id)) u_stack (
		.osc          (osc),
		.reset        (reset),
		.link_data    (link_data),
		.link_valid   (link_valid),
		.link_ready   (link_ready),
		.bd_out_data  (bd_out_data),
		.bd_out_valid (bd_out_valid),
		.bd_out_ready (bd_out_ready),
		.drop_count   (drop_count)
	);

endmodule

/* bz_link_tb.sv */
`timescale 1ns/1ps
module bz_link_tb;
	import bz_pkg::*;

	localparam int               fifo_depth = 8;
	localparam logic [dest_w-1:0] stack_id  = 4'd5;

	// word counts per test size the watchdog
	localparam int n_match      = 6;
	localparam int n_foreign    = 10;
	localparam int n_mixed      = 16;
	localparam int n_hold       = 18;
	localparam int n_random     = 16;
	localparam int total_words  = n_match + n_foreign + n_mixed + n_hold + n_random;
	localparam int word_cycles  = 40; // worst case per word with random ready
	localparam int extra_cycles = 300; // resets and idle windows
	localparam int watchdog_ns  = (total_words * word_cycles + extra_cycles) * 100;

	localparam logic [word_w-1:0] hold_on   = {3'b100, 5'd31, 8'd0, 16'd1};
	localparam logic [word_w-1:0] hold_off  = {3'b100, 5'd31, 8'd0, 16'd0};
	localparam logic [word_w-1:0] other_reg = {3'b100, 5'd7, 8'd0, 16'hffff}; // no effect
	localparam logic [word_w-1:0] nop_w     = {5'b10000, 27'd0};

	logic                    osc = 1'b0;
	logic                    reset;
	logic [word_w-1:0]       pipe_in_data;
	logic                    pipe_in_valid;
	logic                    pipe_in_ready;
	logic [payload_w-1:0]    bd_out_data;
	logic                    bd_out_valid;
	logic                    bd_out_ready;
	logic [drop_count_w-1:0] drop_count;

	logic [31:0] lfsr = 32'd75452;
	logic        rand_ready = 1'b0; // lfsr drives bd_out_ready
	logic [payload_w-1:0] exp_q[$]; // payloads still owed on bd_out
	int          exp_drops = 0;
	int          errors = 0;
	int          n_transfers = 0;

	bz_link_top #(.fifo_depth(fifo_depth), .stack_id(stack_id)) UUT (
		.osc           (osc),
		.reset         (reset),
		.pipe_in_data  (pipe_in_data),
		.pipe_in_valid (pipe_in_valid),
		.pipe_in_ready (pipe_in_ready),
		.bd_out_data   (bd_out_data),
		.bd_out_valid  (bd_out_valid),
		.bd_out_ready  (bd_out_ready),
		.drop_count    (drop_count)
	);

	always #50 osc = ~osc; // 100 ns period

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb)
			s = s ^ 32'h80200003; // x^32 + x^22 + x^2 + x + 1
		return s;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]}; // one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (10) @(negedge osc);
		reset = 1'b0;
		exp_q.delete(); // anything in flight is gone
		exp_drops = 0;
	endtask

	// enters and leaves on a falling edge
	task automatic send_word(input logic [word_w-1:0] w);
		pipe_in_data  = w;
		pipe_in_valid = 1'b1;
		while (!pipe_in_ready)
			@(negedge osc); // back-pressure
		@(negedge osc); // taken on the rising edge in between
		pipe_in_valid = 1'b0;
	endtask

	task automatic send_packet(input logic [dest_w-1:0] dest, input logic [payload_w-1:0] pl);
		if (dest == stack_id)
			exp_q.push_back(pl);
		else
			exp_drops++; // foreign words are only counted
		send_word({1'b0, dest, 6'd0, pl});
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || int'(drop_count) < exp_drops)
			@(negedge osc);
		repeat (5) @(negedge osc); // room for a stray transfer or count
		check_value(drop_count, exp_drops, "drop_count");
	endtask

	// bd_out monitor sees pre-edge values
	always @(posedge osc) begin
		if (!reset && bd_out_valid && bd_out_ready) begin
			n_transfers++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("unexpected bd_out transfer of %0h at %0t ns", bd_out_data, $time);
			end else begin
				check_value(bd_out_data, exp_q.pop_front(), "bd_out payload");
			end
		end
	end

	always @(negedge osc) begin
		logic [31:0] b;
		if (rand_ready) begin
			take_bits(1, b);
			bd_out_ready = b[0];
		end
	end

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic check_reset_state();
		check_value(bd_out_valid, 0, "bd_out_valid after reset");
		check_value(drop_count, 0, "drop_count after reset");
		check_value(pipe_in_ready, 1, "pipe_in_ready after reset");
	endtask

	task automatic deliver_matching();
		logic [31:0] pl;
		for (int i = 0; i < n_match; i++) begin
			take_bits(payload_w, pl);
			send_packet(stack_id, pl[payload_w-1:0]);
		end
		wait_drain();
	endtask

	task automatic drop_foreign();
		logic [31:0] pl;
		logic [31:0] d;
		for (int i = 0; i < n_foreign; i++) begin
			take_bits(dest_w, d);
			take_bits(payload_w, pl);
			if (i % 2 == 0 && d[dest_w-1:0] == stack_id)
				d = d ^ 32'd1; // even slots always foreign
			send_packet(d[dest_w-1:0], pl[payload_w-1:0]);
		end
		wait_drain();
	endtask

	task automatic skip_other_kinds();
		logic [31:0] pl;
		logic [31:0] r;
		for (int i = 0; i < n_mixed / 4; i++) begin
			take_bits(payload_w, pl);
			send_packet(stack_id, pl[payload_w-1:0]);
			send_word(nop_w);
			take_bits(30, r);
			send_word({2'b11, r[29:0]}); // reserved 11x
			take_bits(29, r);
			send_word((i == 0) ? other_reg : {3'b101, r[28:0]}); // reserved 101
		end
		wait_drain();
	endtask

	task automatic hold_and_release();
		logic [31:0] pl;
		for (int i = 0; i < 3; i++) begin
			take_bits(payload_w, pl);
			send_packet(stack_id, pl[payload_w-1:0]); // ahead of the hold
		end
		send_word(hold_on);
		for (int i = 0; i < fifo_depth; i++) begin
			take_bits(payload_w, pl);
			send_packet(stack_id, pl[payload_w-1:0]);
		end
		while (exp_q.size() != fifo_depth)
			@(negedge osc); // earlier words come out
		repeat (20) @(negedge osc);
		check_value(exp_q.size(), fifo_depth, "words still held");
		check_value(pipe_in_ready, 0, "pipe_in_ready with full FIFO");
		// the clear write cannot pass a stalled head so start over from reset
		apply_reset();
		send_word(hold_on);
		send_word(hold_off);
		for (int i = 0; i < 4; i++) begin
			take_bits(payload_w, pl);
			send_packet(stack_id, pl[payload_w-1:0]);
		end
		wait_drain();
	endtask

	task automatic random_ready_order();
		logic [dest_w-1:0]    dests [n_random];
		logic [payload_w-1:0] pls   [n_random];
		logic [31:0]          r;
		for (int i = 0; i < n_random; i++) begin
			take_bits(dest_w, r);
			dests[i] = (i % 2 == 0) ? stack_id : r[dest_w-1:0];
			take_bits(payload_w, r);
			pls[i] = r[payload_w-1:0];
		end
		@(posedge osc);
		rand_ready = 1'b1; // ready pattern starts at the next falling edge
		@(negedge osc);
		for (int i = 0; i < n_random; i++)
			send_packet(dests[i], pls[i]);
		wait_drain();
		@(posedge osc);
		rand_ready = 1'b0;
		@(negedge osc);
		bd_out_ready = 1'b1;
	endtask

	initial begin
		reset         = 1'b1;
		pipe_in_data  = '0;
		pipe_in_valid = 1'b0;
		bd_out_ready  = 1'b1;
		apply_reset();
		check_reset_state();
		deliver_matching();
		drop_foreign();
		skip_other_kinds();
		hold_and_release();
		random_ready_order();
		$display("closing: %0d errors, %0d bd_out transfers, drop_count %0d",
			errors, n_transfers, drop_count);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// watchdog
	initial begin
		#(watchdog_ns);
		$display("timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("Checks failed");
		$finish;
	end

endmodule

/* compile.f */
bz_pkg.sv
host_pipe_fifo.sv
host_word_decoder.sv
link_serializer.sv
host_core.sv
link_deserializer.sv
stack_core.sv
bz_link_top.sv
bz_link_tb.sv
